//--- filelist.f
rtl/apv_format_pkg.sv
rtl/apv_bus_pkg.sv
rtl/sync_fifo.sv
rtl/frame_buffer.sv
rtl/zero_suppressor.sv
rtl/event_status.sv
rtl/register_decoder.sv
rtl/apv_channel_top.sv
verif/tb_clock.sv
verif/apv_channel_tb.sv

//--- rtl/apv_bus_pkg.sv
// user bus and input stream of the channel, word addresses on a 16-bit bus
// every strobe in these types is a single-cycle pulse
package apv_bus_pkg;

	typedef struct packed {
		logic wr;
		logic [12:0] data;
		logic last;
		logic [11:0] baseline;	// valid with the last word only
	} frame_in_t;

	typedef struct packed {
		logic [15:0] addr;
		logic wr;
		logic rd;
		logic [11:0] wdata;
	} user_bus_t;

	typedef struct packed {
		logic wr;
		logic [6:0] addr;
		logic [11:0] data;
	} thr_write_t;

	localparam logic [15:0] ADDR_FIFO_BASE = 16'h4000;
	localparam logic [15:0] ADDR_FIFO_MASK = 16'hF800;	// window 0x4000..0x47FF
	localparam logic [15:0] ADDR_THR_BASE = 16'hD800;
	localparam logic [15:0] ADDR_THR_MASK = 16'hFF80;	// one word per strip
	localparam logic [15:0] ADDR_WORDCOUNT = 16'hC000;
	localparam logic [15:0] ADDR_STATUS = 16'hC010;

endpackage

//--- rtl/apv_channel_top.sv
// processed readout of one APV channel, frames and user bus share CLK
// FIFO depths must be powers of two
module apv_channel_top import apv_format_pkg::*; import apv_bus_pkg::*; #(
	parameter int OUT_FIFO_DEPTH = 2048,
	parameter int FRAME_BUF_DEPTH = 512,
	parameter int MEAN_DEPTH = 32,
	parameter logic [3:0] CH_ID = 4'd0
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic all_clear,
	input  frame_in_t frame_in,
	input  user_bus_t bus,
	input  logic base_sub_en,
	input  logic [4:0] module_id,
	input  logic event_ack,
	output logic [31:0] rdata,
	output logic rvalid,
	output logic event_present
);
	frame_word_t fb_head;
	logic [SAMPLE_W-1:0] fb_baseline;
	logic fb_ready;
	logic fb_pop;
	logic fb_overflow;
	thr_write_t thr_wr;
	out_word_u zs_word;
	out_word_u out_head;
	logic zs_push;
	logic event_done;
	logic out_empty;
	logic out_full;
	logic out_pop;
	logic out_overflow;
	logic [$clog2(OUT_FIFO_DEPTH+1)-1:0] out_used;
	logic apv_fifo_full_l;
	logic proc_fifo_full_l;

	frame_buffer #(.FRAME_BUF_DEPTH(FRAME_BUF_DEPTH), .MEAN_DEPTH(MEAN_DEPTH)) frame_buf (
		.CLK(CLK), .RSTb(RSTb), .clear(all_clear), .frame_in(frame_in),
		.pop(fb_pop), .head(fb_head), .baseline(fb_baseline),
		.frame_ready(fb_ready), .overflow(fb_overflow)
	);

	zero_suppressor #(.CH_ID(CH_ID)) zero_sup (
		.CLK(CLK), .RSTb(RSTb), .clear(all_clear), .thr_wr(thr_wr),
		.base_sub_en(base_sub_en), .module_id(module_id),
		.head(fb_head), .baseline(fb_baseline), .frame_ready(fb_ready),
		.pop(fb_pop), .out_word(zs_word), .out_push(zs_push), .event_done(event_done)
	);

	sync_fifo #(.DEPTH(OUT_FIFO_DEPTH), .WIDTH(OUT_W)) out_fifo (
		.CLK(CLK), .RSTb(RSTb), .clear(all_clear),
		.push(zs_push), .din(zs_word), .pop(out_pop), .dout(out_head),
		.empty(out_empty), .full(out_full), .used(out_used), .overflow(out_overflow)
	);

	event_status ev_status (
		.CLK(CLK), .RSTb(RSTb), .clear(all_clear),
		.event_done(event_done), .event_ack(event_ack),
		.frame_overflow(fb_overflow), .out_overflow(out_overflow),
		.event_present(event_present),
		.apv_fifo_full_l(apv_fifo_full_l), .proc_fifo_full_l(proc_fifo_full_l)
	);

	register_decoder #(.OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)) reg_dec (
		.CLK(CLK), .RSTb(RSTb), .bus(bus),
		.fifo_head(out_head), .fifo_empty(out_empty), .fifo_full(out_full),
		.fifo_used(out_used), .apv_fifo_full_l(apv_fifo_full_l),
		.proc_fifo_full_l(proc_fifo_full_l), .event_present(event_present),
		.thr_wr(thr_wr), .fifo_pop(out_pop), .rdata(rdata), .rvalid(rvalid)
	);

endmodule

//--- rtl/apv_format_pkg.sv
// word formats of one APV readout channel, 13-bit frame words in and 21-bit tagged words out
// the top two bits of an output word pick its view, 00 marks a header
package apv_format_pkg;

	localparam int N_STRIPS = 128;
	localparam int STRIP_AW = 7;
	localparam int SAMPLE_W = 12;
	localparam int FRAME_W = 13;
	localparam int OUT_W = 21;
	localparam logic [SAMPLE_W-1:0] THR_DISABLED = '1;	// strip switched off

	localparam logic [1:0] TAG_STRIP = 2'b01;
	localparam logic [1:0] TAG_TRAILER_A = 2'b10;
	localparam logic [1:0] TAG_TRAILER_B = 2'b11;

	typedef struct packed {
		logic last;	// trailer word of the frame
		logic [FRAME_W-1:0] data;
	} frame_word_t;

	typedef struct packed {
		logic [2:0] zero;
		logic base_msb;	// baseline bit 11
		logic [FRAME_W-1:0] word;
		logic [3:0] ch_id;
	} header_t;

	typedef struct packed {
		logic [1:0] tag;
		logic [STRIP_AW-1:0] addr;
		logic [SAMPLE_W-1:0] value;	// low bits of the subtracted sample
	} strip_t;

	typedef struct packed {
		logic [1:0] tag;
		logic [1:0] zero;
		logic [4:0] module_id;
		logic [SAMPLE_W-1:0] trailer;
	} trailer_a_t;

	typedef struct packed {
		logic [1:0] tag;
		logic [10:0] base_lo;	// baseline bits 10..0
		logic [7:0] count;	// kept strips plus the two trailers
	} trailer_b_t;

	typedef union packed {
		header_t header;
		strip_t strip;
		trailer_a_t trailer_a;
		trailer_b_t trailer_b;
	} out_word_u;

endpackage

//--- rtl/event_status.sv
// counts processed events up to 31, an increment wins over an acknowledge
// overflow flags stay set until clear
module event_status (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  logic event_done,
	input  logic event_ack,
	input  logic frame_overflow,
	input  logic out_overflow,
	output logic event_present,
	output logic apv_fifo_full_l,
	output logic proc_fifo_full_l
);
	logic [4:0] ev_cnt;

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			ev_cnt <= '0;
			event_present <= 1'b0;
			apv_fifo_full_l <= 1'b0;
			proc_fifo_full_l <= 1'b0;
		end
		else if (clear)
		begin
			ev_cnt <= '0;
			event_present <= 1'b0;
			apv_fifo_full_l <= 1'b0;
			proc_fifo_full_l <= 1'b0;
		end
		else
		begin
			event_present <= (ev_cnt != 5'd0);	// one cycle behind the count
			if (event_done)
			begin
				if (ev_cnt != 5'd31)
					ev_cnt <= ev_cnt + 1'b1;
			end
			else if (event_ack && ev_cnt != 5'd0)
				ev_cnt <= ev_cnt - 1'b1;
			if (frame_overflow)
				apv_fifo_full_l <= 1'b1;
			if (out_overflow)
				proc_fifo_full_l <= 1'b1;
		end
	end

endmodule

//--- rtl/frame_buffer.sv
// frames are expected whole, 130 words with the baseline on the last word
// a last word lost to overflow is not counted, so its frame waits for the next one
module frame_buffer import apv_format_pkg::*; import apv_bus_pkg::*; #(
	parameter int FRAME_BUF_DEPTH = 512,
	parameter int MEAN_DEPTH = 32
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  frame_in_t frame_in,
	input  logic pop,
	output frame_word_t head,
	output logic [SAMPLE_W-1:0] baseline,
	output logic frame_ready,
	output logic overflow
);
	localparam int CNT_W = $clog2(FRAME_BUF_DEPTH + 1);

	logic word_empty;
	logic word_full;
	logic word_ovf;
	logic mean_ovf;
	logic frame_in_done;
	logic frame_out_done;
	logic [CNT_W-1:0] frame_cnt;

	assign frame_in_done = frame_in.wr & frame_in.last & ~word_full;
	assign frame_out_done = pop & ~word_empty & head.last;	// trailer leaves
	assign frame_ready = (frame_cnt != '0);
	assign overflow = word_ovf | mean_ovf;

	sync_fifo #(.DEPTH(FRAME_BUF_DEPTH), .WIDTH($bits(frame_word_t))) word_fifo (
		.CLK(CLK), .RSTb(RSTb), .clear(clear),
		.push(frame_in.wr), .din({frame_in.last, frame_in.data}),
		.pop(pop), .dout(head),
		.empty(word_empty), .full(word_full), .used(), .overflow(word_ovf)
	);

	// one baseline per frame, released together with the trailer
	sync_fifo #(.DEPTH(MEAN_DEPTH), .WIDTH(SAMPLE_W)) mean_fifo (
		.CLK(CLK), .RSTb(RSTb), .clear(clear),
		.push(frame_in.wr & frame_in.last), .din(frame_in.baseline),
		.pop(frame_out_done), .dout(baseline),
		.empty(), .full(), .used(), .overflow(mean_ovf)
	);

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
			frame_cnt <= '0;
		else if (clear)
			frame_cnt <= '0;
		else
		begin
			case ({frame_in_done, frame_out_done})
				2'b10: frame_cnt <= frame_cnt + 1'b1;
				2'b01: frame_cnt <= frame_cnt - 1'b1;
				default: frame_cnt <= frame_cnt;
			endcase
		end
	end

endmodule

//--- rtl/register_decoder.sv
// read data and rvalid follow a read strobe by one cycle; a FIFO read pops at once
// threshold writes go straight through in the cycle of the write strobe
module register_decoder import apv_format_pkg::*; import apv_bus_pkg::*; #(
	parameter int OUT_FIFO_DEPTH = 2048
) (
	input  logic CLK,
	input  logic RSTb,
	input  user_bus_t bus,
	input  out_word_u fifo_head,
	input  logic fifo_empty,
	input  logic fifo_full,
	input  logic [$clog2(OUT_FIFO_DEPTH+1)-1:0] fifo_used,
	input  logic apv_fifo_full_l,
	input  logic proc_fifo_full_l,
	input  logic event_present,
	output thr_write_t thr_wr,
	output logic fifo_pop,
	output logic [31:0] rdata,
	output logic rvalid
);
	logic fifo_sel;
	logic thr_sel;
	logic [31:0] rd_mux;

	assign fifo_sel = ((bus.addr & ADDR_FIFO_MASK) == ADDR_FIFO_BASE);
	assign thr_sel = ((bus.addr & ADDR_THR_MASK) == ADDR_THR_BASE);

	assign thr_wr.wr = bus.wr & thr_sel;
	assign thr_wr.addr = bus.addr[STRIP_AW-1:0];	// strip number
	assign thr_wr.data = bus.wdata;
	assign fifo_pop = bus.rd & fifo_sel & ~fifo_empty;

	always_comb
	begin
		rd_mux = '0;
		if (fifo_sel)
		begin
			if (!fifo_empty)
				rd_mux = {{(32 - OUT_W){1'b0}}, fifo_head};
		end
		else if (bus.addr == ADDR_WORDCOUNT)
			rd_mux = 32'(fifo_used);
		else if (bus.addr == ADDR_STATUS)
			rd_mux = {27'd0, event_present, proc_fifo_full_l, apv_fifo_full_l,
				fifo_full, fifo_empty};
	end

	always_ff @(posedge CLK)
	begin
		if (bus.rd)
			rdata <= rd_mux;
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
			rvalid <= 1'b0;
		else
			rvalid <= bus.rd;
	end

endmodule

//--- rtl/sync_fifo.sv
// DEPTH must be a power of two and at least 2; head word shows without a pop
// push into a full FIFO is dropped and flagged, pop from empty is ignored
module sync_fifo #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  logic push,
	input  logic [WIDTH-1:0] din,
	input  logic pop,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] used,
	output logic overflow
);
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty = (used == '0);
	assign full = (used == DEPTH);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign overflow = push & full;	// dropped word
	assign dout = mem[rd_ptr];	// fall-through head

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

endmodule

//--- rtl/zero_suppressor.sv
// one frame at a time, two cycles per strip; a frame starts only once it is complete
// no back-pressure from the output FIFO, words pushed into a full FIFO are lost
module zero_suppressor import apv_format_pkg::*; import apv_bus_pkg::*; #(
	parameter logic [3:0] CH_ID = 4'd0
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  thr_write_t thr_wr,
	input  logic base_sub_en,
	input  logic [4:0] module_id,
	input  frame_word_t head,
	input  logic [SAMPLE_W-1:0] baseline,
	input  logic frame_ready,
	output logic pop,
	output out_word_u out_word,
	output logic out_push,
	output logic event_done
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_RD_THR,
		S_COMPARE,
		S_TRAILER_A,
		S_TRAILER_B
	} state_t;

	state_t state;
	logic [SAMPLE_W-1:0] thr_ram [N_STRIPS];
	logic [SAMPLE_W-1:0] thr_q;
	logic [STRIP_AW-1:0] strip;
	logic [7:0] word_cnt;
	logic [FRAME_W-1:0] sub_val;
	logic [FRAME_W-1:0] diff;
	logic keep;

	always_ff @(posedge CLK)
	begin
		if (thr_wr.wr)
			thr_ram[thr_wr.addr] <= thr_wr.data;
		thr_q <= thr_ram[strip];	// valid in S_COMPARE
	end

	assign sub_val = base_sub_en ? {1'b0, baseline} : '0;
	assign diff = head.data - sub_val;	// wraps mod 2^13
	assign keep = (thr_q != THR_DISABLED) && (diff > {1'b0, thr_q});

	// header, strip samples and trailer leave the frame buffer
	assign pop = (state == S_HEADER) || (state == S_COMPARE) || (state == S_TRAILER_B);

	always_ff @(posedge CLK)
	begin
		case (state)
			S_HEADER:
			begin
				out_word.header.zero <= '0;
				out_word.header.base_msb <= baseline[SAMPLE_W-1];
				out_word.header.word <= head.data;
				out_word.header.ch_id <= CH_ID;
			end
			S_COMPARE:
			begin
				out_word.strip.tag <= TAG_STRIP;
				out_word.strip.addr <= strip;
				out_word.strip.value <= diff[SAMPLE_W-1:0];
			end
			S_TRAILER_A:
			begin
				out_word.trailer_a.tag <= TAG_TRAILER_A;
				out_word.trailer_a.zero <= '0;
				out_word.trailer_a.module_id <= module_id;
				out_word.trailer_a.trailer <= head.data[SAMPLE_W-1:0];
			end
			S_TRAILER_B:
			begin
				out_word.trailer_b.tag <= TAG_TRAILER_B;
				out_word.trailer_b.base_lo <= baseline[10:0];
				out_word.trailer_b.count <= word_cnt;
			end
			default: out_word <= out_word;
		endcase
	end

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			state <= S_IDLE;
			strip <= '0;
			word_cnt <= '0;
			out_push <= 1'b0;
			event_done <= 1'b0;
		end
		else if (clear)
		begin
			state <= S_IDLE;
			strip <= '0;
			word_cnt <= '0;
			out_push <= 1'b0;
			event_done <= 1'b0;
		end
		else
		begin
			out_push <= 1'b0;
			event_done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (frame_ready)
						state <= S_HEADER;
				end
				S_HEADER:
				begin
					out_push <= 1'b1;
					strip <= '0;
					word_cnt <= 8'd2;	// both trailers count
					state <= S_RD_THR;
				end
				S_RD_THR: state <= S_COMPARE;
				S_COMPARE:
				begin
					out_push <= keep;
					if (keep)
						word_cnt <= word_cnt + 1'b1;
					strip <= strip + 1'b1;
					if (strip == STRIP_AW'(N_STRIPS - 1))
						state <= S_TRAILER_A;	// head is the trailer next
					else
						state <= S_RD_THR;
				end
				S_TRAILER_A:
				begin
					out_push <= 1'b1;
					state <= S_TRAILER_B;
				end
				S_TRAILER_B:
				begin
					out_push <= 1'b1;
					event_done <= 1'b1;	// same cycle as the trailer B push
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- verif/apv_channel_tb.sv
// output FIFO is cut to 256 words so that two unsuppressed frames overflow it
// every FIFO read pops, so each word reaches the compare process exactly once
module apv_channel_tb import apv_format_pkg::*; import apv_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SEED = 9044;
	localparam int LIMIT = 4000;	// cycles per wait
	localparam logic [3:0] CH = 4'd9;
	localparam logic [4:0] MOD_ID = 5'd19;

	logic CLK;
	logic RSTb;
	logic all_clear;
	frame_in_t frame_in;
	user_bus_t bus;
	logic base_sub_en;
	logic [4:0] module_id;
	logic event_ack;
	logic [31:0] rdata;
	logic rvalid;
	logic event_present;

	logic [SAMPLE_W-1:0] thr [N_STRIPS];	// mirror of the threshold RAM
	logic [SAMPLE_W-1:0] samples [N_STRIPS];
	logic [OUT_W-1:0] exp_q [$];
	logic [31:0] got_q [$];	// full read word, upper bits must stay zero
	string cur_test;
	int check_errors = 0;
	int other_errors = 0;

	tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(2)) clk_gen (.CLK(CLK), .RSTb(RSTb));

	apv_channel_top #(.OUT_FIFO_DEPTH(256), .FRAME_BUF_DEPTH(512), .MEAN_DEPTH(32),
		.CH_ID(CH)) dut (
		.CLK(CLK), .RSTb(RSTb), .all_clear(all_clear), .frame_in(frame_in), .bus(bus),
		.base_sub_en(base_sub_en), .module_id(module_id), .event_ack(event_ack),
		.rdata(rdata), .rvalid(rvalid), .event_present(event_present)
	);

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			check_errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// expected output words of one frame, appended to exp_q
	function automatic void build_expected(input logic [FRAME_W-1:0] hdr,
		input logic [FRAME_W-1:0] trl, input logic [SAMPLE_W-1:0] base, input logic sub_en);
		out_word_u w;
		logic [FRAME_W-1:0] diff;
		int kept;
		kept = 0;
		w = '0;
		w.header.base_msb = base[11];
		w.header.word = hdr;
		w.header.ch_id = CH;
		exp_q.push_back(w);
		for (int s = 0; s < N_STRIPS; s++)
		begin
			diff = {1'b0, samples[s]} - (sub_en ? {1'b0, base} : 13'd0);	// mod 2^13
			if (thr[s] != THR_DISABLED && diff > {1'b0, thr[s]})
			begin
				w = '0;
				w.strip.tag = 2'b01;
				w.strip.addr = STRIP_AW'(s);
				w.strip.value = diff[11:0];
				exp_q.push_back(w);
				kept++;
			end
		end
		w = '0;
		w.trailer_a.tag = 2'b10;
		w.trailer_a.module_id = MOD_ID;
		w.trailer_a.trailer = trl[11:0];
		exp_q.push_back(w);
		w = '0;
		w.trailer_b.tag = 2'b11;
		w.trailer_b.base_lo = base[10:0];
		w.trailer_b.count = 8'(kept + 2);
		exp_q.push_back(w);
	endfunction

	task automatic compare_words();
		forever
		begin
			@(posedge CLK);
			if (got_q.size() != 0)
			begin
				if (exp_q.size() != 0)
					compare_value(cur_test, 32'(exp_q.pop_front()), got_q.pop_front());
				else
				begin
					other_errors++;
					$display("%s: the DUT returned word %h that was not expected", cur_test,
						got_q.pop_front());
				end
			end
		end
	endtask

	task automatic write_reg(input logic [15:0] waddr, input logic [11:0] wdata);
		@(posedge CLK);
		bus <= '{addr: waddr, wr: 1'b1, rd: 1'b0, wdata: wdata};
		@(posedge CLK);
		bus <= '0;
	endtask

	task automatic read_reg(input logic [15:0] raddr, output logic [31:0] data);
		int n;
		n = 0;
		@(posedge CLK);
		bus <= '{addr: raddr, wr: 1'b0, rd: 1'b1, wdata: 12'd0};
		@(posedge CLK);
		bus <= '0;
		compare_value({cur_test, " rvalid before response"}, 32'd0, 32'(rvalid));
		do
		begin
			@(posedge CLK);
			n++;
		end
		while (!rvalid && n < LIMIT);
		if (!rvalid)
		begin
			other_errors++;
			$display("%s: no read response from address %h", cur_test, raddr);
		end
		else
			compare_value({cur_test, " read latency"}, 32'd1, 32'(n));
		data = rdata;
	endtask

	task automatic load_thresholds();
		for (int s = 0; s < N_STRIPS; s++)
			write_reg(ADDR_THR_BASE + 16'(s), thr[s]);
	endtask

	// header, 128 strips, then the trailer carrying the baseline
	task automatic push_frame(input logic [FRAME_W-1:0] hdr, input logic [FRAME_W-1:0] trl,
		input logic [SAMPLE_W-1:0] base);
		frame_in_t w;
		w = '0;
		w.wr = 1'b1;
		w.data = hdr;
		@(posedge CLK);
		frame_in <= w;
		for (int s = 0; s < N_STRIPS; s++)
		begin
			w.data = {1'b0, samples[s]};
			@(posedge CLK);
			frame_in <= w;
		end
		w.data = trl;
		w.last = 1'b1;
		w.baseline = base;
		@(posedge CLK);
		frame_in <= w;
		@(posedge CLK);
		frame_in <= '0;
	endtask

	task automatic ack_event();
		@(posedge CLK);
		event_ack <= 1'b1;
		@(posedge CLK);
		event_ack <= 1'b0;
	endtask

	task automatic wait_event(input logic level);
		int n;
		n = 0;
		while (event_present !== level && n < LIMIT)
		begin
			@(posedge CLK);
			n++;
		end
		if (event_present !== level)
		begin
			other_errors++;
			$display("%s: timed out waiting for event_present to go %0b", cur_test, level);
		end
	endtask

	task automatic process_frame(input logic [FRAME_W-1:0] hdr, input logic [FRAME_W-1:0] trl,
		input logic [SAMPLE_W-1:0] base);
		push_frame(hdr, trl, base);
		wait_event(1'b1);
		ack_event();
		wait_event(1'b0);
	endtask

	task automatic drain_and_compare();
		logic [31:0] d;
		int cnt;
		int n;
		read_reg(ADDR_WORDCOUNT, d);
		compare_value({cur_test, " word count"}, 32'(exp_q.size()), d);
		cnt = int'(d);
		for (int i = 0; i < cnt && i < 256; i++)
		begin
			read_reg(ADDR_FIFO_BASE + 16'(i), d);
			got_q.push_back(d);
		end
		n = 0;
		while (got_q.size() != 0 && n < LIMIT)
		begin
			@(posedge CLK);
			n++;
		end
		if (got_q.size() != 0 || exp_q.size() != 0)
		begin
			other_errors++;
			$display("%s: %0d expected words never arrived", cur_test, exp_q.size());
			exp_q.delete();
			got_q.delete();
		end
	endtask

	initial
	begin
		logic [31:0] d;
		logic [FRAME_W-1:0] hdr;
		logic [FRAME_W-1:0] trl;
		logic [SAMPLE_W-1:0] base;
		int n;
		void'($urandom(SEED));
		all_clear = 1'b0;
		frame_in = '0;
		bus = '0;
		base_sub_en = 1'b0;
		module_id = MOD_ID;
		event_ack = 1'b0;
		cur_test = "reset";
		n = 0;
		while (RSTb !== 1'b1 && n < LIMIT)
		begin
			@(posedge CLK);
			n++;
		end
		if (RSTb !== 1'b1)
		begin
			other_errors++;
			$display("reset was never released");
		end
		fork
			compare_words();
		join_none

		cur_test = "disabled thresholds";
		for (int s = 0; s < N_STRIPS; s++)
		begin
			thr[s] = THR_DISABLED;
			samples[s] = 12'($urandom);
		end
		load_thresholds();
		hdr = 13'($urandom);
		trl = 13'($urandom);
		base = 12'($urandom);
		build_expected(hdr, trl, base, 1'b0);
		process_frame(hdr, trl, base);
		drain_and_compare();

		cur_test = "random thresholds";
		for (int s = 0; s < N_STRIPS; s++)
			thr[s] = ($urandom % 8 == 0) ? THR_DISABLED : 12'($urandom);
		samples[3] = 12'h000;	// below any baseline, wraps with subtraction
		samples[77] = 12'h005;
		thr[3] = 12'h0FF;
		thr[77] = 12'h7FF;
		load_thresholds();
		build_expected(hdr, trl, base, 1'b0);
		process_frame(hdr, trl, base);
		drain_and_compare();

		cur_test = "baseline subtraction";
		base = 12'h800 + 12'($urandom % 12'h400);
		@(posedge CLK);
		base_sub_en <= 1'b1;
		build_expected(hdr, trl, base, 1'b1);
		process_frame(hdr, trl, base);
		drain_and_compare();

		cur_test = "two events";
		for (int s = 0; s < N_STRIPS; s++)
			thr[s] = THR_DISABLED;
		load_thresholds();
		build_expected(hdr, trl, base, 1'b1);
		build_expected(~hdr, ~trl, ~base, 1'b1);
		push_frame(hdr, trl, base);
		push_frame(~hdr, ~trl, ~base);
		n = 0;
		d = '0;
		while (d != 32'd6 && n < 1000)
		begin
			read_reg(ADDR_WORDCOUNT, d);
			n++;
		end
		if (d != 32'd6)
		begin
			other_errors++;
			$display("%s: timed out waiting for both frames to be processed", cur_test);
		end
		ack_event();
		read_reg(ADDR_STATUS, d);
		compare_value({cur_test, " present after one ack"}, 32'd1, {31'd0, d[4]});
		ack_event();
		wait_event(1'b0);
		read_reg(ADDR_STATUS, d);
		compare_value({cur_test, " present after two acks"}, 32'd0, {31'd0, d[4]});
		drain_and_compare();

		cur_test = "output overflow";
		@(posedge CLK);
		base_sub_en <= 1'b0;
		for (int s = 0; s < N_STRIPS; s++)
		begin
			thr[s] = 12'd0;
			samples[s] = 12'(1 + $urandom % 4095);	// every strip survives
		end
		load_thresholds();
		process_frame(hdr, trl, base);
		push_frame(hdr, trl, base);
		wait_event(1'b1);
		read_reg(ADDR_STATUS, d);
		compare_value({cur_test, " status"}, 32'h1A, d);	// present, overflow, full
		@(posedge CLK);
		all_clear <= 1'b1;
		@(posedge CLK);
		all_clear <= 1'b0;
		read_reg(ADDR_WORDCOUNT, d);
		compare_value({cur_test, " word count after clear"}, 32'd0, d);
		read_reg(ADDR_STATUS, d);
		compare_value({cur_test, " status after clear"}, 32'h01, d);

		$display("errors: %0d check failures, %0d other failures", check_errors, other_errors);
		if (check_errors + other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- verif/tb_clock.sv
// free-running testbench clock, reset held low for RESET_CYCLES rising edges
module tb_clock #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK,
	output logic RSTb
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		CLK = 1'b0;
		forever
			#(PERIOD_NS / 2.0) CLK = ~CLK;
	end

	initial
	begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge CLK);
		RSTb <= 1'b1;
	end

endmodule
